//--- verilog/dataflowPkg.sv
`default_nettype none

package dataflowPkg;

    ////////////////////////////////////////
    // token widths
    ////////////////////////////////////////
    localparam int DataWidth = 8;

    ////////////////////////////////////////
    // token types
    ////////////////////////////////////////
    typedef logic [DataWidth-1:0] dataT;  // data token
    typedef logic [0:0]           condT;  // branch condition token

endpackage

`default_nettype wire

//--- verilog/bufferPkg.sv
`default_nettype none

package bufferPkg;

    // single slot of a half-buffer
    typedef enum logic {
        SlotEmpty = 1'b0,
        SlotFull  = 1'b1
    } slotStateT;

endpackage

`default_nettype wire

//--- verilog/tehb.sv
`timescale 1ns/1ps
`default_nettype none

module tehb #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rstn,

    input  logic [WIDTH-1:0] inData,
    input  logic             inValid,
    output logic             inReady,

    output logic [WIDTH-1:0] outData,
    output logic             outValid,
    input  logic             outReady
);

    bufferPkg::slotStateT slotState;
    logic [WIDTH-1:0]     slotData;
    logic                 slotFull;
    logic                 capture;

    assign slotFull = (slotState == bufferPkg::SlotFull);
    assign capture  = !slotFull && inValid && !outReady;  // consumer stalls on a live token

    // bypass while empty
    assign inReady  = !slotFull;
    assign outValid = inValid || slotFull;
    assign outData  = slotFull ? slotData : inData;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            slotState <= bufferPkg::SlotEmpty;
        end else if (capture) begin
            slotState <= bufferPkg::SlotFull;
        end else if (slotFull && outReady) begin
            slotState <= bufferPkg::SlotEmpty;  // stored token drains
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            slotData <= inData;
        end
    end

endmodule

`default_nettype wire

//--- verilog/oehb.sv
`timescale 1ns/1ps
`default_nettype none

module oehb #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rstn,

    input  logic [WIDTH-1:0] inData,
    input  logic             inValid,
    output logic             inReady,

    output logic [WIDTH-1:0] outData,
    output logic             outValid,
    input  logic             outReady
);

    bufferPkg::slotStateT slotState;
    logic [WIDTH-1:0]     slotData;
    logic                 accept;

    assign outValid = (slotState == bufferPkg::SlotFull);
    assign outData  = slotData;
    assign inReady  = !outValid || outReady;  // slot frees up this cycle
    assign accept   = inValid && inReady;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            slotState <= bufferPkg::SlotEmpty;
        end else if (accept) begin
            slotState <= bufferPkg::SlotFull;
        end else if (outReady) begin
            slotState <= bufferPkg::SlotEmpty;
        end
    end

    // every accepted token is registered
    always_ff @(posedge clk) begin
        if (accept) begin
            slotData <= inData;
        end
    end

endmodule

`default_nettype wire

//--- verilog/elasticBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module elasticBuffer #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rstn,

    input  logic [WIDTH-1:0] inData,
    input  logic             inValid,
    output logic             inReady,

    output logic [WIDTH-1:0] outData,
    output logic             outValid,
    input  logic             outReady
);

    // between the two half-buffers
    logic [WIDTH-1:0] midData;
    logic             midValid;
    logic             midReady;

    // tehb cuts the ready path
    tehb #(
        .WIDTH(WIDTH)
    ) tehb_inst (
        .clk     (clk),
        .rstn    (rstn),
        .inData  (inData),
        .inValid (inValid),
        .inReady (inReady),
        .outData (midData),
        .outValid(midValid),
        .outReady(midReady)
    );

    // oehb cuts the valid path
    oehb #(
        .WIDTH(WIDTH)
    ) oehb_inst (
        .clk     (clk),
        .rstn    (rstn),
        .inData  (midData),
        .inValid (midValid),
        .inReady (midReady),
        .outData (outData),
        .outValid(outValid),
        .outReady(outReady)
    );

endmodule

`default_nettype wire

//--- verilog/eagerFork.sv
`timescale 1ns/1ps
`default_nettype none

module eagerFork #(
    parameter int OUTPUTS = 2
) (
    input  logic                 clk,
    input  logic                 rstn,

    input  dataflowPkg::dataT    inData,
    input  logic                 inValid,
    output logic                 inReady,

    output dataflowPkg::dataT    outData,
    output logic [OUTPUTS-1:0]   outValid,
    input  logic [OUTPUTS-1:0]   outReady
);

    logic [OUTPUTS-1:0] taken;      // output already has the current token
    logic [OUTPUTS-1:0] takenNext;
    logic [OUTPUTS-1:0] laneDone;   // taken earlier or taking now
    logic               tokenMoves;

    ////////////////////////////////////////
    // combinational side
    ////////////////////////////////////////
    assign outData  = inData;  // same token on every lane
    assign outValid = {OUTPUTS{inValid}} & ~taken;
    assign laneDone = taken | outReady;

    // AND reduction over all lanes
    assign inReady    = &laneDone;
    assign tokenMoves = inValid && inReady;

    always_comb begin
        if (tokenMoves) begin
            takenNext = '0;  // all lanes served, start fresh
        end else begin
            takenNext = taken | (outValid & outReady);
        end
    end

    ////////////////////////////////////////
    // taken flags
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            taken <= '0;
        end else begin
            taken <= takenNext;
        end
    end

endmodule

`default_nettype wire

//--- verilog/condBranch.sv
`timescale 1ns/1ps
`default_nettype none

module condBranch (
    input  dataflowPkg::dataT inData,
    input  logic              inValid,
    output logic              inReady,

    input  dataflowPkg::condT condIn,
    input  logic              condValid,
    output logic              condReady,

    output dataflowPkg::dataT trueData,
    output logic              trueValid,
    input  logic              trueReady,

    output dataflowPkg::dataT falseData,
    output logic              falseValid,
    input  logic              falseReady
);

    logic joinValid;
    logic selReady;

    // join of data and condition
    assign joinValid = inValid && condValid;

    assign trueValid  = joinValid && condIn[0];
    assign falseValid = joinValid && !condIn[0];
    assign trueData   = inData;
    assign falseData  = inData;

    assign selReady = condIn[0] ? trueReady : falseReady;

    // both sides acknowledged together
    assign inReady   = selReady && condValid;
    assign condReady = selReady && inValid;

endmodule

`default_nettype wire

//--- verilog/dataflowTop.sv
`timescale 1ns/1ps
`default_nettype none

module dataflowTop (
    input  logic              clk,
    input  logic              rstn,

    input  dataflowPkg::dataT inData,
    input  logic              inValid,
    output logic              inReady,

    input  dataflowPkg::condT condIn,
    input  logic              condValid,
    output logic              condReady,

    output dataflowPkg::dataT trueData,
    output logic              trueValid,
    input  logic              trueReady,

    output dataflowPkg::dataT falseData,
    output logic              falseValid,
    input  logic              falseReady,

    output dataflowPkg::dataT tapData,
    output logic              tapValid,
    input  logic              tapReady
);

    dataflowPkg::dataT bufData;
    logic              bufValid;
    logic              bufReady;

    dataflowPkg::condT bufCond;
    logic              bufCondValid;
    logic              bufCondReady;

    dataflowPkg::dataT forkData;
    logic [1:0]        forkValid;   // lane 0 branch, lane 1 tap
    logic [1:0]        forkReady;

    ////////////////////////////////////////
    // input buffers
    ////////////////////////////////////////
    elasticBuffer #(
        .WIDTH(dataflowPkg::DataWidth)
    ) dataBuffer (
        .clk     (clk),
        .rstn    (rstn),
        .inData  (inData),
        .inValid (inValid),
        .inReady (inReady),
        .outData (bufData),
        .outValid(bufValid),
        .outReady(bufReady)
    );

    elasticBuffer #(
        .WIDTH(1)
    ) condBuffer (
        .clk     (clk),
        .rstn    (rstn),
        .inData  (condIn),
        .inValid (condValid),
        .inReady (condReady),
        .outData (bufCond),
        .outValid(bufCondValid),
        .outReady(bufCondReady)
    );

    ////////////////////////////////////////
    // fork and branch
    ////////////////////////////////////////
    eagerFork #(
        .OUTPUTS(2)
    ) dataFork (
        .clk     (clk),
        .rstn    (rstn),
        .inData  (bufData),
        .inValid (bufValid),
        .inReady (bufReady),
        .outData (forkData),
        .outValid(forkValid),
        .outReady(forkReady)
    );

    condBranch branchUnit (
        .inData    (forkData),
        .inValid   (forkValid[0]),
        .inReady   (forkReady[0]),
        .condIn    (bufCond),
        .condValid (bufCondValid),
        .condReady (bufCondReady),
        .trueData  (trueData),
        .trueValid (trueValid),
        .trueReady (trueReady),
        .falseData (falseData),
        .falseValid(falseValid),
        .falseReady(falseReady)
    );

    assign tapData      = forkData;  // tap lane
    assign tapValid     = forkValid[1];
    assign forkReady[1] = tapReady;

endmodule

`default_nettype wire

//--- dv/dataflowTb.sv
`timescale 1ns/1ps
`default_nettype none

module dataflowTb;

    localparam int ClkPeriod     = 100;
    localparam int ResetCycles   = 10;
    localparam int NumTokens     = 400;
    localparam int ForkCycles    = 12;
    localparam int TimeoutCycles = NumTokens * 20;

    logic              clk;
    logic              rstn;
    dataflowPkg::dataT inData;
    logic              inValid;
    logic              inReady;
    dataflowPkg::condT condIn;
    logic              condValid;
    logic              condReady;
    dataflowPkg::dataT trueData;
    logic              trueValid;
    logic              trueReady;
    dataflowPkg::dataT falseData;
    logic              falseValid;
    logic              falseReady;
    dataflowPkg::dataT tapData;
    logic              tapValid;
    logic              tapReady;

    // reference model
    dataflowPkg::dataT pendingData[$];  // accepted, waiting for a condition
    dataflowPkg::condT pendingCond[$];
    dataflowPkg::dataT trueQ[$];
    dataflowPkg::dataT falseQ[$];
    dataflowPkg::dataT tapQ[$];
    dataflowPkg::condT routeQ[$];       // route of each pair, in branch order

    logic [31:0] lcgState = 32'd49541;
    int          dataAccepted = 0;
    int          condAccepted = 0;
    int          branchCount = 0;
    int          tapCount = 0;
    int          cycleCount = 0;
    logic        dataMoved = 1'b0;
    logic        condMoved = 1'b0;
    logic        randomReady = 1'b0;

    dataflowTop dataflowTop_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic abortRun();
        $display("Something failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic checkData(input string what, input dataflowPkg::dataT got,
                             input dataflowPkg::dataT exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCond(input string what, input dataflowPkg::condT got,
                             input dataflowPkg::condT exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abortRun();
        end
    endtask

    // a held token stays on the bus until it moves
    task automatic driveInputs(input logic noGaps);
        logic [31:0] r;
        r = lcgNext();
        if (!inValid || dataMoved) begin
            inValid = (dataAccepted < NumTokens) && (noGaps || r[31:30] != 2'b00);
            inData  = r[23:16];
        end
        r = lcgNext();
        if (!condValid || condMoved) begin
            condValid = (condAccepted < NumTokens) && (noGaps || r[31:30] != 2'b00);
            condIn    = r[20];
        end
        if (randomReady) begin
            r = lcgNext();
            trueReady  = r[31] | r[30];
            falseReady = r[29] | r[28];
            tapReady   = r[27] | r[26];
        end
    endtask

    task automatic branchOut(input logic route, input dataflowPkg::dataT got);
        dataflowPkg::dataT expData;
        if (routeQ.size() == 0 || (route ? trueQ.size() : falseQ.size()) == 0) begin
            $display("branch output delivered a token that was never sent, at %0t", $time);
            abortRun();
        end
        expData = route ? trueQ.pop_front() : falseQ.pop_front();
        checkCond("route of branch token", route, routeQ.pop_front());
        checkData(route ? "trueData" : "falseData", got, expData);
        branchCount++;
    endtask

    // inputs are settled here, so these are the handshakes of the next edge
    task automatic sampleChannels();
        dataflowPkg::condT c;
        dataMoved = inValid && inReady;
        condMoved = condValid && condReady;
        if (dataMoved) begin
            pendingData.push_back(inData);
            tapQ.push_back(inData);
            dataAccepted++;
        end
        if (condMoved) begin
            pendingCond.push_back(condIn);
            condAccepted++;
        end
        while (pendingData.size() > 0 && pendingCond.size() > 0) begin
            c = pendingCond.pop_front();
            routeQ.push_back(c);
            if (c[0]) trueQ.push_back(pendingData.pop_front());
            else falseQ.push_back(pendingData.pop_front());
        end
        if (trueValid && trueReady) branchOut(1'b1, trueData);
        if (falseValid && falseReady) branchOut(1'b0, falseData);
        if (tapValid && tapReady) begin
            if (tapQ.size() == 0) begin
                $display("tap output delivered a token that was never sent, at %0t", $time);
                abortRun();
            end
            checkData("tapData", tapData, tapQ.pop_front());
            tapCount++;
        end
    endtask

    task automatic runCycle(input logic noGaps);
        @(negedge clk);
        driveInputs(noGaps);
        #1;
        sampleChannels();
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        rstn       = 1'b0;
        inData     = '0;
        inValid    = 1'b0;
        condIn     = '0;
        condValid  = 1'b0;
        trueReady  = 1'b1;
        falseReady = 1'b1;
        tapReady   = 1'b0;  // tap stalls for the fork test
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        #1;
        checkFlag("trueValid after reset", trueValid, 1'b0);
        checkFlag("falseValid after reset", falseValid, 1'b0);
        checkFlag("tapValid after reset", tapValid, 1'b0);
        checkFlag("inReady after reset", inReady, 1'b1);
        checkFlag("condReady after reset", condReady, 1'b1);

        // eager fork, branch goes ahead of the stalled tap
        repeat (ForkCycles) runCycle(1'b1);
        checkCount("branch tokens with tap stalled", branchCount, 1);
        checkCount("data tokens accepted with tap stalled", dataAccepted, 2);
        checkFlag("tapValid with tap stalled", tapValid, 1'b1);
        checkData("tapData with tap stalled", tapData, tapQ[0]);

        randomReady = 1'b1;
        while (dataAccepted < NumTokens || condAccepted < NumTokens
               || trueQ.size() > 0 || falseQ.size() > 0 || tapQ.size() > 0) begin
            runCycle(1'b0);
        end

        if (routeQ.size() == 0 && pendingData.size() == 0 && pendingCond.size() == 0
            && tapCount == NumTokens && branchCount == NumTokens) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("tokens left over in the model, %0d tap and %0d branch seen",
                     tapCount, branchCount);
            abortRun();
        end
    end

    // stall watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: outputs stalled, run stopped after %0d cycles", cycleCount);
            abortRun();
        end
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/dataflowPkg.sv
verilog/bufferPkg.sv
verilog/tehb.sv
verilog/oehb.sv
verilog/elasticBuffer.sv
verilog/eagerFork.sv
verilog/condBranch.sv
verilog/dataflowTop.sv
dv/dataflowTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = dataflowTb
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: sim clean

# pass only when the pass message shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(BUILD)
